/* files.f */
+incdir+include
verilog/dds_pkg.sv
verilog/frame_parser.sv
verilog/wave_shaper.sv
verilog/dds_channel.sv
verilog/dds_dual_top.sv
test/tb_dds_dual.sv

/* include/dds_cfg.svh */
`ifndef DDS_CFG_SVH
`define DDS_CFG_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define DDS_ACC_W       24  // phase accumulator
`define DDS_PHASE_W     12  // phase field, wave address
`define DDS_AMP_W       12
`define DDS_OFS_W       13
`define DDS_DUTY_W      10  // 1/1024 period units
`define DDS_SAMPLE_W    14

////////////////////////////////////////
// frame format
////////////////////////////////////////
`define DDS_HDR_BYTES   4
`define DDS_HDR_WORD    32'h0000_0101   // 00 00 01 01, first byte on top
`define DDS_FRAME_LEN   22              // payload bytes after length
`define DDS_CH_BYTES    11              // one channel block

`endif

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dds_dual -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dds_dual)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

/* test/dds_stim.txt */
# name gap bad_hdr len accept nchk, then per channel (ch1, ch2):
# run wave(dec) freq amp offset phase duty (hex)
saw_tri       0 0 22 1 64 1 1 012345 fff 0100 000 000 1 2 0a0000 800 0200 400 000
saw_tri_gaps  1 0 22 1 64 1 2 031000 a55 0010 123 000 1 1 004567 7ff 0fff 800 000
square_dc     0 0 22 1 64 1 0 100000 fff 0020 000 180 1 3 000000 abc 1000 000 000
square_duty   1 0 22 1 64 1 0 0c0000 9a3 0000 200 3ff 1 0 200000 fff 0400 100 001
run_off       0 0 22 1 64 1 1 054321 fff 0000 000 000 0 2 0a0000 c00 0100 300 000
bad_hdr       0 1 22 0 64 1 9 111111 222 0333 444 155 1 9 111111 222 0333 444 155
bad_len       1 0 21 0 64 1 1 111111 222 0333 444 155 1 2 111111 222 0333 444 155
after_rej     0 0 22 1 64 1 2 008000 fff 1fff 7ff 000 1 1 123456 fff 0000 000 000
b2b_first     0 0 22 1 0  1 5 020000 fff 0050 000 000 1 1 040000 fff 0000 000 000
b2b_second    0 0 22 1 64 1 1 070000 abc 0007 0f0 000 1 2 003000 fff 0100 a00 000

/* test/tb_dds_dual.sv */
`timescale 1ns/1ps
`include "dds_cfg.svh"

module tb_dds_dual
    import dds_pkg::*;
();

    logic                       clk = 1'b0;
    logic                       i_arst_n;
    logic [7:0]                 i_byte;
    logic                       i_byte_vld;
    logic [`DDS_SAMPLE_W-1:0]   o_dds1_data;
    logic [`DDS_SAMPLE_W-1:0]   o_dds2_data;

    int             cyc = 0;        // rising edges so far
    int             ce = 0;         // edge of the last commit
    dds_cfg_t       m_cfg [2];      // configuration the model expects
    logic           chk_on = 1'b0;
    logic [31:0]    lfsr = 32'h6386_92b0;
    logic [127:0]   cur_name;
    int             errs = 0;
    int             tests = 0;
    int             bad_tests = 0;

    dds_dual_top dut
    (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_byte      (i_byte),
        .i_byte_vld  (i_byte_vld),
        .o_dds1_data (o_dds1_data),
        .o_dds2_data (o_dds2_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // shaper rule from wave address to scaled sample
    function automatic int sample_model(input dds_cfg_t c, input logic [23:0] a);
        logic [11:0] p;
        int u;
        p = a[23:12] + c.phase;
        case (int'(c.wave))
            0: u = (p[11:2] < c.duty) ? 4095 : 0;
            1: u = int'(p);
            2: u = (p < 2048) ? 2 * int'(p[10:0]) : 2 * (2047 - int'(p[10:0]));
            3: u = 4095;
            default: u = 0;
        endcase
        return int'(c.offset) + (int'(c.amp) * u) / 4096;
    endfunction

    function automatic int expected(input int ch);
        logic [63:0] a;
        a = 0;
        if (m_cfg[ch].run)
        begin
            a = 64'(cyc - ce - 2) * 64'(m_cfg[ch].freq);   // (n-1) * freq
        end
        return sample_model(m_cfg[ch], a[23:0]);
    endfunction

    task automatic check(input logic [127:0] name, input int exp, input int act);
        if (exp != act)
        begin
            $display("FAILED %0s: expected %0d, actual %0d", name, exp, act);
            errs++;
        end
    endtask

    // one edge then both outputs compared 1 ns later
    task automatic tick();
        @(posedge clk);
        #1;
        if (chk_on)
        begin
            check(cur_name, expected(0), int'(o_dds1_data));
            check(cur_name, expected(1), int'(o_dds2_data));
        end
    endtask

    task automatic drive_byte(input logic [7:0] b, input int gap);
        logic [2:0] k;
        if (gap != 0)
        begin
            k[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            if (k[0])
            begin
                k[1] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                k[2] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                i_byte_vld = 1'b0;
                for (int i = 0; i <= int'(k[2:1]) && i < 8; i++)
                begin
                    tick();
                end
            end
        end
        i_byte     = b;
        i_byte_vld = 1'b1;
        tick();
        i_byte_vld = 1'b0;
    endtask

    task automatic push_cfg(ref logic [7:0] q [$], input dds_cfg_t c);
        q.push_back({4'h0, c.run, c.wave});
        q.push_back(c.freq[23:16]);
        q.push_back(c.freq[15:8]);
        q.push_back(c.freq[7:0]);
        q.push_back(8'(c.amp >> 8));
        q.push_back(c.amp[7:0]);
        q.push_back(8'(c.offset >> 8));
        q.push_back(c.offset[7:0]);
        q.push_back(c.phase[11:4]);
        q.push_back({c.phase[3:0], 2'b00, c.duty[9:8]});    // byte 9 holds both
        q.push_back(c.duty[7:0]);
    endtask

    task automatic run_file();
        int fd;
        int n;
        string line;
        int gap;
        int bad_hdr;
        int len;
        int acc;
        int nchk;
        int r [2];
        int w [2];
        int f [2];
        int am [2];
        int of [2];
        int ph [2];
        int du [2];
        int e0;
        dds_cfg_t c [2];
        logic [7:0] q [$];
        fd = $fopen("test/dds_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file test/dds_stim.txt");
            errs++;
            return;
        end
        while (!$feof(fd) && tests < 100)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %h %h %h %h %h %d %d %h %h %h %h %h",
                cur_name, gap, bad_hdr, len, acc, nchk,
                r[0], w[0], f[0], am[0], of[0], ph[0], du[0],
                r[1], w[1], f[1], am[1], of[1], ph[1], du[1]);
            if (n != 20)
            begin
                $display("stimulus line has %0d fields instead of 20: %s", n, line);
                errs++;
                continue;
            end
            e0 = errs;
            q.delete();
            q.push_back(8'h00);
            q.push_back(8'h00);
            q.push_back(bad_hdr != 0 ? 8'h02 : 8'h01);
            q.push_back(8'h01);
            q.push_back(8'(len >> 8));
            q.push_back(8'(len));
            for (int ch = 0; ch < 2; ch++)
            begin
                c[ch].run    = r[ch][0];
                c[ch].wave   = wave_type_e'(w[ch][2:0]);
                c[ch].freq   = f[ch][23:0];
                c[ch].amp    = am[ch][11:0];
                c[ch].offset = of[ch][12:0];
                c[ch].phase  = ph[ch][11:0];
                c[ch].duty   = du[ch][9:0];
                push_cfg(q, c[ch]);
            end
            foreach (q[i])
            begin
                drive_byte(q[i], gap);
            end
            tick();     // channels still on old settings during the strobe
            if (acc != 0)
            begin
                ce = cyc - 1;
                m_cfg[0] = c[0];
                m_cfg[1] = c[1];
            end
            for (int i = 0; i < nchk; i++)
            begin
                tick();
            end
            tests++;
            if (errs != e0)
            begin
                bad_tests++;
            end
            $display("test %0s: %0d mismatches", cur_name, errs - e0);
        end
        $fclose(fd);
    endtask

    initial
    begin
        #200000;
        $display("timeout: the run did not finish within 200 us");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        i_arst_n   = 1'b0;
        i_byte     = 8'h00;
        i_byte_vld = 1'b0;
        m_cfg[0]   = '0;
        m_cfg[1]   = '0;
        for (int i = 0; i < 4; i++)
        begin
            tick();
        end
        i_arst_n = 1'b1;

        // outputs idle at zero until a frame arrives
        cur_name = "reset";
        chk_on   = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            tick();
        end
        tests++;
        bad_tests += (errs != 0) ? 1 : 0;
        $display("test reset: %0d mismatches", errs);

        run_file();

        $display("%0d tests, %0d failed, %0d mismatches", tests, bad_tests, errs);
        if (errs == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog/dds_channel.sv */
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_channel
    import dds_pkg::*;
(
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  dds_cfg_t                    i_cfg,
    input  logic                        i_cfg_vld,
    output logic [`DDS_SAMPLE_W-1:0]    o_data
);

    dds_cfg_t                       cfg;
    logic [`DDS_ACC_W-1:0]          acc;
    logic [`DDS_SAMPLE_W-1:0]       sample;

    ////////////////////////////////////////
    // settings and phase accumulator
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cfg <= '0;
            acc <= '0;
        end
        else if (i_cfg_vld)
        begin
            cfg <= i_cfg;
            acc <= '0;              // restart from phase zero
        end
        else if (cfg.run)
        begin
            acc <= acc + cfg.freq;  // wraps mod 2^24
        end
    end

    wave_shaper u_shaper
    (
        .i_acc_top  (acc[`DDS_ACC_W-1 -: `DDS_PHASE_W]),
        .i_cfg      (cfg),
        .o_sample   (sample)
    );

    // one clk behind the accumulator
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_data <= '0;
        end
        else
        begin
            o_data <= sample;
        end
    end

    a_acc_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        (!cfg.run && !i_cfg_vld) |=> $stable(acc));

endmodule

/* verilog/dds_dual_top.sv */
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_dual_top
    import dds_pkg::*;
(
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic [7:0]                  i_byte,
    input  logic                        i_byte_vld,
    output logic [`DDS_SAMPLE_W-1:0]    o_dds1_data,
    output logic [`DDS_SAMPLE_W-1:0]    o_dds2_data
);

    dds_cfg_t   cfg1;
    dds_cfg_t   cfg2;
    logic       cfg_vld;   // shared commit strobe

    frame_parser u_parser
    (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_byte     (i_byte),
        .i_byte_vld (i_byte_vld),
        .o_cfg1     (cfg1),
        .o_cfg2     (cfg2),
        .o_cfg_vld  (cfg_vld)
    );

    dds_channel u_ch1
    (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_cfg      (cfg1),
        .i_cfg_vld  (cfg_vld),
        .o_data     (o_dds1_data)
    );

    dds_channel u_ch2
    (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_cfg      (cfg2),
        .i_cfg_vld  (cfg_vld),
        .o_data     (o_dds2_data)
    );

endmodule

/* verilog/dds_pkg.sv */
`include "dds_cfg.svh"

package dds_pkg;

    // waveform selector, codes 4..7 reserved and give a flat zero
    typedef enum logic [2:0]
    {
        WAVE_SQUARE = 3'd0,
        WAVE_SAW    = 3'd1,
        WAVE_TRI    = 3'd2,
        WAVE_DC     = 3'd3
    } wave_type_e;

    // one channel's settings, 75 bits
    typedef struct packed
    {
        logic                       run;
        wave_type_e                 wave;
        logic [`DDS_ACC_W-1:0]      freq;   // phase increment per clk
        logic [`DDS_AMP_W-1:0]      amp;
        logic [`DDS_OFS_W-1:0]      offset;
        logic [`DDS_PHASE_W-1:0]    phase;
        logic [`DDS_DUTY_W-1:0]     duty;
    } dds_cfg_t;

endpackage

/* verilog/frame_parser.sv */
`timescale 1ns/1ps
`include "dds_cfg.svh"

module frame_parser
    import dds_pkg::*;
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic [7:0]  i_byte,
    input  logic        i_byte_vld,
    output dds_cfg_t    o_cfg1,
    output dds_cfg_t    o_cfg2,
    output logic        o_cfg_vld
);

    localparam int          HDR_W     = $clog2(`DDS_HDR_BYTES);
    localparam int          CNT_W     = $clog2(`DDS_FRAME_LEN);
    localparam int          BLK_W     = 8 * `DDS_CH_BYTES;
    localparam logic [31:0] HDR_WORD  = `DDS_HDR_WORD;
    localparam logic [HDR_W-1:0] HDR_LAST = HDR_W'(`DDS_HDR_BYTES - 1);
    localparam logic [CNT_W-1:0] CH1_LAST = CNT_W'(`DDS_CH_BYTES - 1);
    localparam logic [CNT_W-1:0] PAY_LAST = CNT_W'(`DDS_FRAME_LEN - 1);

    typedef enum logic [1:0]
    {
        ST_HUNT,
        ST_LEN_H,
        ST_LEN_L,
        ST_PAYLOAD
    } state_e;

    state_e                 state;
    logic [HDR_W-1:0]       hdr_idx;    // header bytes matched so far
    logic [7:0]             hdr_exp;
    logic [CNT_W-1:0]       cnt;        // payload byte index
    logic [7:0]             len_hi;
    logic [BLK_W-9:0]       sh;         // previous 10 payload bytes
    dds_cfg_t               ch1_stage;
    dds_cfg_t               blk_cfg;

    // block bytes with the first byte on top
    function automatic dds_cfg_t unpack_block(input logic [BLK_W-1:0] blk);
        dds_cfg_t c;
        c.run    = blk[83];
        c.wave   = wave_type_e'(blk[82:80]);   // reserved codes kept as is
        c.freq   = blk[79:56];
        c.amp    = blk[40 +: `DDS_AMP_W];
        c.offset = blk[24 +: `DDS_OFS_W];
        c.phase  = blk[12 +: `DDS_PHASE_W];    // phase and duty share byte 9
        c.duty   = blk[0 +: `DDS_DUTY_W];
        return c;
    endfunction

    assign hdr_exp = HDR_WORD[8*(HDR_LAST - hdr_idx) +: 8];
    assign blk_cfg = unpack_block({sh, i_byte});

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state     <= ST_HUNT;
            hdr_idx   <= '0;
            cnt       <= '0;
            o_cfg_vld <= 1'b0;
            o_cfg1    <= '0;
            o_cfg2    <= '0;
        end
        else
        begin
            o_cfg_vld <= 1'b0;
            if (i_byte_vld)
            begin
                case (state)
                    ST_HUNT:
                    begin
                        if (i_byte == hdr_exp)
                        begin
                            if (hdr_idx == HDR_LAST)
                            begin
                                state   <= ST_LEN_H;
                                hdr_idx <= '0;
                            end
                            else
                            begin
                                hdr_idx <= hdr_idx + 1'b1;
                            end
                        end
                        else if (i_byte == 8'h00)
                        begin
                            hdr_idx <= HDR_W'(1);   // restart on a fresh 00
                        end
                        else
                        begin
                            hdr_idx <= '0;
                        end
                    end
                    ST_LEN_H:
                    begin
                        state <= ST_LEN_L;
                    end
                    ST_LEN_L:
                    begin
                        if ({len_hi, i_byte} == 16'(`DDS_FRAME_LEN))
                        begin
                            state <= ST_PAYLOAD;
                            cnt   <= '0;
                        end
                        else
                        begin
                            state <= ST_HUNT;   // bad length drops the frame
                        end
                    end
                    ST_PAYLOAD:
                    begin
                        if (cnt == PAY_LAST)
                        begin
                            state     <= ST_HUNT;
                            o_cfg1    <= ch1_stage;
                            o_cfg2    <= blk_cfg;
                            o_cfg_vld <= 1'b1;  // both channels at once
                        end
                        else
                        begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default:
                    begin
                        state <= ST_HUNT;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // field assembly
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (i_byte_vld)
        begin
            if (state == ST_LEN_H)
            begin
                len_hi <= i_byte;
            end
            if (state == ST_PAYLOAD)
            begin
                sh <= {sh[BLK_W-17:0], i_byte};
                if (cnt == CH1_LAST)
                begin
                    ch1_stage <= blk_cfg;   // held until ch2 block ends
                end
            end
        end
    end

    a_vld_single: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_cfg_vld |=> !o_cfg_vld);

endmodule

/* verilog/wave_shaper.sv */
`timescale 1ns/1ps
`include "dds_cfg.svh"

module wave_shaper
    import dds_pkg::*;
(
    input  logic [`DDS_PHASE_W-1:0]     i_acc_top,
    input  dds_cfg_t                    i_cfg,
    output logic [`DDS_SAMPLE_W-1:0]    o_sample
);

    localparam int PW = `DDS_PHASE_W;
    localparam int DW = `DDS_DUTY_W;
    localparam int MW = `DDS_AMP_W + PW;

    logic [PW-1:0]  p;      // wave address
    logic [PW-1:0]  u;      // unit wave, full scale 4095
    logic [MW-1:0]  prod;

    assign p = i_acc_top + i_cfg.phase;    // wraps mod 4096

    ////////////////////////////////////////
    // unit waveform
    ////////////////////////////////////////
    always_comb
    begin
        case (i_cfg.wave)
            WAVE_SQUARE:
            begin
                if (p[PW-1 -: DW] < i_cfg.duty)
                begin
                    u = '1;
                end
                else
                begin
                    u = '0;
                end
            end
            WAVE_SAW:
            begin
                u = p;
            end
            WAVE_TRI:
            begin
                // falling half uses 2047 - low bits, same as inverting them
                if (!p[PW-1])
                begin
                    u = {p[PW-2:0], 1'b0};
                end
                else
                begin
                    u = {~p[PW-2:0], 1'b0};
                end
            end
            WAVE_DC:
            begin
                u = '1;
            end
            default:
            begin
                u = '0;     // reserved codes
            end
        endcase
    end

    ////////////////////////////////////////
    // scale and shift
    ////////////////////////////////////////
    assign prod = MW'(i_cfg.amp) * MW'(u);

    // max 8191 + 4094, fits 14 bits without clipping
    assign o_sample = `DDS_SAMPLE_W'(i_cfg.offset) + `DDS_SAMPLE_W'(prod[MW-1:PW]);

endmodule
